// File: verilog/mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	// Register number width
	localparam int reg_addr_w = 5;
	// Data and address width
	localparam int data_w = 32;
	// Data RAM depth in words
	localparam int dmem_words = 64;

	// First fetch address after reset
	localparam logic [data_w-1:0] reset_pc = 32'h0000_0000;
	// Link register of jal
	localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

	// Stage of first operand use, counted in stages after D
	localparam logic [1:0] use_d = 2'd0;
	localparam logic [1:0] use_e = 2'd1;
	localparam logic [1:0] use_m = 2'd2;
	// Operand not read at all
	localparam logic [1:0] use_none = 2'd3;

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	// Where a stage's result comes from
	typedef enum logic [1:0] {
		res_none = 2'b00,
		res_alu  = 2'b01,
		res_dm   = 2'b10,
		res_pc   = 2'b11
	} res_src_t;

	// Operand forwarding selects
	typedef enum logic [2:0] {
		fwd_rf    = 3'd0,
		fwd_w     = 3'd1,
		fwd_m_pc  = 3'd2,
		fwd_m_alu = 3'd3,
		fwd_e_pc  = 3'd4
	} fwd_sel_t;

	// Primary opcode field
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} op_t;

	// Function field of special opcode
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23
	} funct_t;

	// ALU operations
	typedef enum logic [1:0] {
		alu_add = 2'd0,
		alu_sub = 2'd1,
		alu_or  = 2'd2,
		alu_lui = 2'd3
	} alu_op_t;

endpackage

// File: verilog/bypass.sv
`timescale 1ns/1ps

module bypass (
	input  logic [mips_pkg::reg_addr_w-1:0] a1_d,
	input  logic [mips_pkg::reg_addr_w-1:0] a2_d,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_d,
	input  logic [mips_pkg::reg_addr_w-1:0] a1_e,
	input  logic [mips_pkg::reg_addr_w-1:0] a2_e,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_e,
	input  logic [mips_pkg::reg_addr_w-1:0] a1_m,
	input  logic [mips_pkg::reg_addr_w-1:0] a2_m,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_m,
	input  logic [mips_pkg::reg_addr_w-1:0] a1_w,
	input  logic [mips_pkg::reg_addr_w-1:0] a2_w,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_w,
	input  mips_pkg::res_src_t              res_e,
	input  mips_pkg::res_src_t              res_m,
	input  mips_pkg::res_src_t              res_w,
	output mips_pkg::fwd_sel_t              rsd_sel,
	output mips_pkg::fwd_sel_t              rtd_sel,
	output mips_pkg::fwd_sel_t              rse_sel,
	output mips_pkg::fwd_sel_t              rte_sel,
	output mips_pkg::fwd_sel_t              rtm_sel
);

	// Source matches a real destination
	function automatic logic hit(
		input logic [mips_pkg::reg_addr_w-1:0] src,
		input logic [mips_pkg::reg_addr_w-1:0] dst
	);
		return (dst != '0) && (src == dst);
	endfunction

	// Oldest path, any written result in W
	function automatic mips_pkg::fwd_sel_t from_w(input logic [mips_pkg::reg_addr_w-1:0] src);
		if (hit(src, a3_w) && res_w != mips_pkg::res_none)
			return mips_pkg::fwd_w;
		return mips_pkg::fwd_rf;
	endfunction

	// M holds alu or pc values ready, loads still in flight
	function automatic mips_pkg::fwd_sel_t from_m(input logic [mips_pkg::reg_addr_w-1:0] src);
		if (hit(src, a3_m) && res_m == mips_pkg::res_alu)
			return mips_pkg::fwd_m_alu;
		if (hit(src, a3_m) && res_m == mips_pkg::res_pc)
			return mips_pkg::fwd_m_pc;
		return from_w(src);
	endfunction

	// Only a link value exists yet in E
	function automatic mips_pkg::fwd_sel_t from_e(input logic [mips_pkg::reg_addr_w-1:0] src);
		if (hit(src, a3_e) && res_e == mips_pkg::res_pc)
			return mips_pkg::fwd_e_pc;
		return from_m(src);
	endfunction

	//////////////////////////////////////////////////
	// Selects per consumer stage
	//////////////////////////////////////////////////
	always_comb begin
		// D operands, for beq compare and the D/E load
		rsd_sel = from_e(a1_d);
		rtd_sel = from_e(a2_d);
		// E operands, into the ALU
		rse_sel = from_m(a1_e);
		rte_sel = from_m(a2_e);
		// Store data late in M
		rtm_sel = from_w(a2_m);
	end

endmodule

// File: verilog/stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl (
	input  logic [mips_pkg::reg_addr_w-1:0] a1_d,
	input  logic [mips_pkg::reg_addr_w-1:0] a2_d,
	input  logic [1:0]                      use_rs_d,
	input  logic [1:0]                      use_rt_d,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_e,
	input  logic [mips_pkg::reg_addr_w-1:0] a3_m,
	input  mips_pkg::res_src_t              res_e,
	input  mips_pkg::res_src_t              res_m,
	output logic                            stall
);

	// Stages until a producer in E has its value
	function automatic logic [1:0] ready_e(input mips_pkg::res_src_t res);
		case (res)
			mips_pkg::res_alu: return 2'd1;
			mips_pkg::res_dm:  return 2'd2;
			default:           return 2'd0;
		endcase
	endfunction

	// Same for M, only a load still lags
	function automatic logic [1:0] ready_m(input mips_pkg::res_src_t res);
		return (res == mips_pkg::res_dm) ? 2'd1 : 2'd0;
	endfunction

	// Producer late for this source
	function automatic logic late(
		input logic [mips_pkg::reg_addr_w-1:0] src,
		input logic [1:0]                      use_t
	);
		logic late_e;
		logic late_m;
		late_e = (a3_e != '0) && (src == a3_e) && (use_t < ready_e(res_e));
		late_m = (a3_m != '0) && (src == a3_m) && (use_t < ready_m(res_m));
		// use_none never compares below a latency
		return late_e || late_m;
	endfunction

	always_comb begin
		stall = late(a1_d, use_rs_d) || late(a2_d, use_rt_d);
	end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [31:0]                     instr,
	output logic [mips_pkg::reg_addr_w-1:0] a1,
	output logic [mips_pkg::reg_addr_w-1:0] a2,
	output logic [mips_pkg::reg_addr_w-1:0] a3,
	output mips_pkg::res_src_t              res,
	output mips_pkg::alu_op_t               alu_op,
	output logic                            imm_sel,
	output logic                            mem_we,
	output logic                            is_beq,
	output logic                            is_jal,
	output logic [1:0]                      use_rs,
	output logic [1:0]                      use_rt
);

	mips_pkg::op_t    op;
	mips_pkg::funct_t funct;
	logic [4:0]       rs;
	logic [4:0]       rt;
	logic [4:0]       rd;

	// Instruction fields
	assign op    = mips_pkg::op_t'(instr[31:26]);
	assign funct = mips_pkg::funct_t'(instr[5:0]);
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];

	always_comb begin
		// Defaults decode as nop
		a3      = '0;
		res     = mips_pkg::res_none;
		alu_op  = mips_pkg::alu_add;
		imm_sel = 1'b0;
		mem_we  = 1'b0;
		is_beq  = 1'b0;
		is_jal  = 1'b0;
		use_rs  = mips_pkg::use_none;
		use_rt  = mips_pkg::use_none;
		case (op)
			mips_pkg::op_special: begin
				// Unknown funct, including sll nop, writes nothing
				if (funct == mips_pkg::fn_addu || funct == mips_pkg::fn_subu) begin
					a3     = rd;
					res    = mips_pkg::res_alu;
					alu_op = (funct == mips_pkg::fn_subu) ? mips_pkg::alu_sub : mips_pkg::alu_add;
					use_rs = mips_pkg::use_e;
					use_rt = mips_pkg::use_e;
				end
			end
			mips_pkg::op_ori: begin
				a3      = rt;
				res     = mips_pkg::res_alu;
				alu_op  = mips_pkg::alu_or;
				imm_sel = 1'b1;
				use_rs  = mips_pkg::use_e;
			end
			mips_pkg::op_lui: begin
				a3      = rt;
				res     = mips_pkg::res_alu;
				alu_op  = mips_pkg::alu_lui;
				imm_sel = 1'b1;
			end
			mips_pkg::op_lw: begin
				a3      = rt;
				res     = mips_pkg::res_dm;
				imm_sel = 1'b1;
				use_rs  = mips_pkg::use_e;
			end
			mips_pkg::op_sw: begin
				mem_we  = 1'b1;
				imm_sel = 1'b1;
				use_rs  = mips_pkg::use_e;
				// Store data only needed at the RAM
				use_rt  = mips_pkg::use_m;
			end
			mips_pkg::op_beq: begin
				is_beq = 1'b1;
				use_rs = mips_pkg::use_d;
				use_rt = mips_pkg::use_d;
			end
			mips_pkg::op_jal: begin
				is_jal = 1'b1;
				a3     = mips_pkg::link_reg;
				res    = mips_pkg::res_pc;
			end
			default: ;
		endcase
		// Unread sources go to r0 so they never match
		a1 = (use_rs != mips_pkg::use_none) ? rs : '0;
		a2 = (use_rt != mips_pkg::use_none) ? rt : '0;
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            we,
	input  logic [mips_pkg::reg_addr_w-1:0] wa,
	input  logic [mips_pkg::data_w-1:0]     wd,
	input  logic [mips_pkg::reg_addr_w-1:0] ra1,
	input  logic [mips_pkg::reg_addr_w-1:0] ra2,
	output logic [mips_pkg::data_w-1:0]     rd1,
	output logic [mips_pkg::data_w-1:0]     rd2
);

	logic [mips_pkg::data_w-1:0] regs [2**mips_pkg::reg_addr_w];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Plain reads, W results arrive through the bypass selects
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input  mips_pkg::alu_op_t           op,
	input  logic [mips_pkg::data_w-1:0] a,
	input  logic [mips_pkg::data_w-1:0] b,
	output logic [mips_pkg::data_w-1:0] y
);

	always_comb begin
		case (op)
			mips_pkg::alu_sub: y = a - b;
			mips_pkg::alu_or:  y = a | b;
			// Immediate into the upper half
			mips_pkg::alu_lui: y = {b[15:0], 16'h0000};
			// addu, and address for lw and sw
			default:           y = a + b;
		endcase
	end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        we,
	input  logic [mips_pkg::data_w-1:0] addr,
	input  logic [mips_pkg::data_w-1:0] wdata,
	output logic [mips_pkg::data_w-1:0] rdata
);

	logic [mips_pkg::data_w-1:0]               mem [mips_pkg::dmem_words];
	logic [$clog2(mips_pkg::dmem_words)-1:0] idx;

	// Word index, byte offset dropped
	assign idx = addr[$clog2(mips_pkg::dmem_words)+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mips_pkg::dmem_words; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	// Read in the same cycle for the M stage
	assign rdata = mem[idx];

endmodule

// File: verilog/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [31:0]                     imem_data,
	input  logic [mips_pkg::data_w-1:0]     dmem_rdata,
	output logic [mips_pkg::data_w-1:0]     imem_addr,
	output logic                            dmem_we,
	output logic [mips_pkg::data_w-1:0]     dmem_addr,
	output logic [mips_pkg::data_w-1:0]     dmem_wdata,
	output logic                            wb_en,
	output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
	output logic [mips_pkg::data_w-1:0]     wb_data
);

	// F stage
	logic [31:0] pc_f;
	logic [31:0] pc_next;
	logic        stall;

	// D stage
	logic [31:0]        instr_d;
	logic [31:0]        pc_d;
	logic [4:0]         a1_d, a2_d, a3_d;
	logic [1:0]         use_rs_d, use_rt_d;
	logic               imm_sel_d, mem_we_d, is_beq_d, is_jal_d;
	logic [31:0]        rf_rd1, rf_rd2, rs_fwd_d, rt_fwd_d;
	logic [31:0]        imm_ext_d, pc4_d, pc8_d, br_target, j_target;
	mips_pkg::res_src_t res_d;
	mips_pkg::alu_op_t  alu_op_d;
	mips_pkg::fwd_sel_t rsd_sel, rtd_sel;

	// E stage
	logic [4:0]         a1_e, a2_e, a3_e;
	logic               imm_sel_e, mem_we_e;
	logic [31:0]        rs_val_e, rt_val_e, imm_e, pc8_e;
	logic [31:0]        rs_fwd_e, rt_fwd_e, alu_y;
	mips_pkg::res_src_t res_e;
	mips_pkg::alu_op_t  alu_op_e;
	mips_pkg::fwd_sel_t rse_sel, rte_sel;

	// M stage
	logic [4:0]         a1_m, a2_m, a3_m;
	logic               mem_we_m;
	logic [31:0]        alu_m, rt_val_m, pc8_m;
	mips_pkg::res_src_t res_m;
	mips_pkg::fwd_sel_t rtm_sel;

	// W stage
	logic [4:0]         a1_w, a2_w, a3_w;
	logic [31:0]        alu_w, dm_w, pc8_w, wd_w;
	mips_pkg::res_src_t res_w;

	// Operand value for a forwarding select
	// Base is the regfile read or the copy held in the stage
	function automatic logic [31:0] pick(input mips_pkg::fwd_sel_t sel, input logic [31:0] base);
		case (sel)
			mips_pkg::fwd_w:     return wd_w;
			mips_pkg::fwd_m_pc:  return pc8_m;
			mips_pkg::fwd_m_alu: return alu_m;
			mips_pkg::fwd_e_pc:  return pc8_e;
			default:             return base;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////
	assign imem_addr = pc_f;

	// Target lands after the delay slot now in F
	always_comb begin
		pc_next = pc_f + 32'd4;
		if (is_beq_d && rs_fwd_d == rt_fwd_d)
			pc_next = br_target;
		else if (is_jal_d)
			pc_next = j_target;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc_f <= mips_pkg::reset_pc;
		else if (!stall)
			pc_f <= pc_next;
	end

	// F/D register holds on stall
	always_ff @(posedge clk) begin
		if (rst) begin
			instr_d <= '0;
		end else if (!stall) begin
			instr_d <= imem_data;
			pc_d    <= pc_f;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	decoder u_decoder (
		.instr(instr_d), .a1(a1_d), .a2(a2_d), .a3(a3_d), .res(res_d),
		.alu_op(alu_op_d), .imm_sel(imm_sel_d), .mem_we(mem_we_d),
		.is_beq(is_beq_d), .is_jal(is_jal_d), .use_rs(use_rs_d), .use_rt(use_rt_d)
	);

	reg_file u_reg_file (
		.clk(clk), .rst(rst), .we(wb_en), .wa(a3_w), .wd(wd_w),
		.ra1(a1_d), .ra2(a2_d), .rd1(rf_rd1), .rd2(rf_rd2)
	);

	bypass u_bypass (
		.a1_d(a1_d), .a2_d(a2_d), .a3_d(a3_d),
		.a1_e(a1_e), .a2_e(a2_e), .a3_e(a3_e),
		.a1_m(a1_m), .a2_m(a2_m), .a3_m(a3_m),
		.a1_w(a1_w), .a2_w(a2_w), .a3_w(a3_w),
		.res_e(res_e), .res_m(res_m), .res_w(res_w),
		.rsd_sel(rsd_sel), .rtd_sel(rtd_sel),
		.rse_sel(rse_sel), .rte_sel(rte_sel), .rtm_sel(rtm_sel)
	);

	stall_ctrl u_stall_ctrl (
		.a1_d(a1_d), .a2_d(a2_d), .use_rs_d(use_rs_d), .use_rt_d(use_rt_d),
		.a3_e(a3_e), .a3_m(a3_m), .res_e(res_e), .res_m(res_m), .stall(stall)
	);

	always_comb begin
		rs_fwd_d = pick(rsd_sel, rf_rd1);
		rt_fwd_d = pick(rtd_sel, rf_rd2);
	end

	// ori zero-extends and lui ignores the upper half
	assign imm_ext_d = (alu_op_d == mips_pkg::alu_or) ? {16'h0000, instr_d[15:0]} :
		{{16{instr_d[15]}}, instr_d[15:0]};
	assign pc4_d     = pc_d + 32'd4;
	// Link skips the delay slot
	assign pc8_d     = pc_d + 32'd8;
	assign br_target = pc4_d + {imm_ext_d[29:0], 2'b00};
	assign j_target  = {pc4_d[31:28], instr_d[25:0], 2'b00};

	// D/E register takes a bubble on stall
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			a1_e     <= '0;
			a2_e     <= '0;
			a3_e     <= '0;
			res_e    <= mips_pkg::res_none;
			mem_we_e <= 1'b0;
		end else begin
			a1_e     <= a1_d;
			a2_e     <= a2_d;
			a3_e     <= a3_d;
			res_e    <= res_d;
			mem_we_e <= mem_we_d;
		end
		alu_op_e  <= alu_op_d;
		imm_sel_e <= imm_sel_d;
		rs_val_e  <= rs_fwd_d;
		rt_val_e  <= rt_fwd_d;
		imm_e     <= imm_ext_d;
		pc8_e     <= pc8_d;
	end

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////
	always_comb begin
		rs_fwd_e = pick(rse_sel, rs_val_e);
		rt_fwd_e = pick(rte_sel, rt_val_e);
	end

	alu u_alu (
		.op(alu_op_e), .a(rs_fwd_e), .b(imm_sel_e ? imm_e : rt_fwd_e), .y(alu_y)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			a1_m     <= '0;
			a2_m     <= '0;
			a3_m     <= '0;
			res_m    <= mips_pkg::res_none;
			mem_we_m <= 1'b0;
		end else begin
			a1_m     <= a1_e;
			a2_m     <= a2_e;
			a3_m     <= a3_e;
			res_m    <= res_e;
			mem_we_m <= mem_we_e;
		end
		alu_m    <= alu_y;
		rt_val_m <= rt_fwd_e;
		pc8_m    <= pc8_e;
	end

	//////////////////////////////////////////////////
	// Memory and writeback
	//////////////////////////////////////////////////
	assign dmem_we    = mem_we_m;
	assign dmem_addr  = alu_m;

	// Store data from a load just ahead comes in from W
	always_comb begin
		dmem_wdata = pick(rtm_sel, rt_val_m);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			a1_w  <= '0;
			a2_w  <= '0;
			a3_w  <= '0;
			res_w <= mips_pkg::res_none;
		end else begin
			a1_w  <= a1_m;
			a2_w  <= a2_m;
			a3_w  <= a3_m;
			res_w <= res_m;
		end
		alu_w <= alu_m;
		dm_w  <= dmem_rdata;
		pc8_w <= pc8_m;
	end

	always_comb begin
		case (res_w)
			mips_pkg::res_dm: wd_w = dm_w;
			mips_pkg::res_pc: wd_w = pc8_w;
			default:          wd_w = alu_w;
		endcase
	end

	// Trace matches what the regfile stores
	assign wb_en   = (a3_w != '0) && (res_w != mips_pkg::res_none);
	assign wb_reg  = a3_w;
	assign wb_data = wd_w;

endmodule

// File: verilog/mips_top.sv
`timescale 1ns/1ps

module mips_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [31:0]                     imem_data,
	output logic [mips_pkg::data_w-1:0]     imem_addr,
	output logic                            wb_en,
	output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
	output logic [mips_pkg::data_w-1:0]     wb_data
);

	// Core to data RAM, all in M
	logic                        dmem_we;
	logic [mips_pkg::data_w-1:0] dmem_addr;
	logic [mips_pkg::data_w-1:0] dmem_wdata;
	logic [mips_pkg::data_w-1:0] dmem_rdata;

	mips_core u_core (
		.clk(clk),
		.rst(rst),
		.imem_data(imem_data),
		.dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	data_mem u_dmem (
		.clk(clk),
		.rst(rst),
		.we(dmem_we),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.rdata(dmem_rdata)
	);

endmodule

// File: bench/tb_program.svh
// MIPS field codes
localparam logic [5:0] opc_jal  = 6'h03;
localparam logic [5:0] opc_beq  = 6'h04;
localparam logic [5:0] opc_ori  = 6'h0d;
localparam logic [5:0] opc_lui  = 6'h0f;
localparam logic [5:0] opc_lw   = 6'h23;
localparam logic [5:0] opc_sw   = 6'h2b;
localparam logic [5:0] fnc_addu = 6'h21;
localparam logic [5:0] fnc_subu = 6'h23;

localparam int prog_words = 41;
localparam int exp_writes = 28;

// Instruction words by word address
logic [31:0] prog [prog_words];
// Expected trace as {register, value} in program order
logic [36:0] exp_tab [exp_writes];

// Register-type word with shamt zero
function automatic logic [31:0] r_format(
	input logic [5:0] fn,
	input logic [4:0] rd,
	input logic [4:0] rs,
	input logic [4:0] rt
);
	return {6'h00, rs, rt, rd, 5'h00, fn};
endfunction

// Immediate-type word
function automatic logic [31:0] i_format(
	input logic [5:0]  op,
	input logic [4:0]  rt,
	input logic [4:0]  rs,
	input logic [15:0] imm
);
	return {op, rs, rt, imm};
endfunction

// Jump-type word with a word index target
function automatic logic [31:0] j_format(input logic [5:0] op, input logic [25:0] index);
	return {op, index};
endfunction

task automatic load_tables();
	//////////////////////////////////////////////////
	// ALU chains through M and W forwarding
	//////////////////////////////////////////////////
	prog[0]  = i_format(opc_ori, 5'd1, 5'd0, 16'h0005);
	prog[1]  = i_format(opc_ori, 5'd2, 5'd0, 16'h0003);
	prog[2]  = r_format(fnc_addu, 5'd3, 5'd1, 5'd2);
	prog[3]  = r_format(fnc_subu, 5'd4, 5'd3, 5'd1);
	prog[4]  = i_format(opc_lui, 5'd5, 5'd0, 16'h1234);
	prog[5]  = i_format(opc_ori, 5'd5, 5'd5, 16'h5678);
	// Zero minus 3 wraps around
	prog[6]  = r_format(fnc_subu, 5'd6, 5'd0, 5'd2);
	prog[7]  = r_format(fnc_addu, 5'd7, 5'd6, 5'd5);
	//////////////////////////////////////////////////
	// Loads and stores with load-use
	//////////////////////////////////////////////////
	prog[8]  = i_format(opc_sw, 5'd5, 5'd0, 16'h0010);
	prog[9]  = i_format(opc_lw, 5'd8, 5'd0, 16'h0010);
	prog[10] = r_format(fnc_addu, 5'd9, 5'd8, 5'd1);
	prog[11] = i_format(opc_ori, 5'd10, 5'd0, 16'h00aa);
	// Store data straight from the ori
	prog[12] = i_format(opc_sw, 5'd10, 5'd0, 16'h0014);
	prog[13] = i_format(opc_lw, 5'd11, 5'd0, 16'h0014);
	// Store data straight from the load
	prog[14] = i_format(opc_sw, 5'd11, 5'd0, 16'h0018);
	prog[15] = i_format(opc_lw, 5'd12, 5'd0, 16'h0018);
	prog[16] = r_format(fnc_addu, 5'd13, 5'd12, 5'd9);
	//////////////////////////////////////////////////
	// Branches with delay slot
	//////////////////////////////////////////////////
	prog[17] = i_format(opc_ori, 5'd14, 5'd0, 16'h0007);
	// 7 vs 5 is not taken
	// A wrong take lands on 24
	prog[18] = i_format(opc_beq, 5'd1, 5'd14, 16'h0005);
	prog[19] = i_format(opc_ori, 5'd15, 5'd0, 16'h0001);
	prog[20] = i_format(opc_ori, 5'd16, 5'd0, 16'h0002);
	prog[21] = i_format(opc_lw, 5'd17, 5'd0, 16'h0010);
	// Taken right after the load to 25
	prog[22] = i_format(opc_beq, 5'd5, 5'd17, 16'h0002);
	prog[23] = r_format(fnc_addu, 5'd18, 5'd17, 5'd1);
	prog[24] = i_format(opc_ori, 5'd19, 5'd0, 16'hdead);
	prog[25] = i_format(opc_ori, 5'd20, 5'd0, 16'h0020);
	prog[26] = i_format(opc_ori, 5'd21, 5'd0, 16'h0020);
	prog[27] = i_format(opc_ori, 5'd22, 5'd0, 16'h0055);
	// Taken to 31 with rt written two before
	prog[28] = i_format(opc_beq, 5'd21, 5'd20, 16'h0002);
	prog[29] = r_format(fnc_addu, 5'd23, 5'd20, 5'd21);
	prog[30] = i_format(opc_ori, 5'd24, 5'd0, 16'hbeef);
	//////////////////////////////////////////////////
	// Link register and register 0
	//////////////////////////////////////////////////
	prog[31] = j_format(opc_jal, 26'd36);
	prog[32] = r_format(fnc_addu, 5'd25, 5'd31, 5'd0);
	prog[33] = i_format(opc_ori, 5'd26, 5'd0, 16'h0bad);
	prog[34] = i_format(opc_ori, 5'd27, 5'd0, 16'h0bad);
	prog[35] = i_format(opc_ori, 5'd29, 5'd0, 16'h0bad);
	prog[36] = r_format(fnc_addu, 5'd26, 5'd31, 5'd1);
	prog[37] = r_format(fnc_subu, 5'd27, 5'd26, 5'd31);
	prog[38] = i_format(opc_ori, 5'd0, 5'd0, 16'h1234);
	prog[39] = r_format(fnc_addu, 5'd0, 5'd1, 5'd2);
	prog[40] = r_format(fnc_addu, 5'd28, 5'd0, 5'd1);

	// Hand-worked writes without skipped or r0 writes
	exp_tab[0]  = {5'd1, 32'h0000_0005};
	exp_tab[1]  = {5'd2, 32'h0000_0003};
	exp_tab[2]  = {5'd3, 32'h0000_0008};
	exp_tab[3]  = {5'd4, 32'h0000_0003};
	exp_tab[4]  = {5'd5, 32'h1234_0000};
	exp_tab[5]  = {5'd5, 32'h1234_5678};
	exp_tab[6]  = {5'd6, 32'hffff_fffd};
	exp_tab[7]  = {5'd7, 32'h1234_5675};
	exp_tab[8]  = {5'd8, 32'h1234_5678};
	exp_tab[9]  = {5'd9, 32'h1234_567d};
	exp_tab[10] = {5'd10, 32'h0000_00aa};
	exp_tab[11] = {5'd11, 32'h0000_00aa};
	exp_tab[12] = {5'd12, 32'h0000_00aa};
	exp_tab[13] = {5'd13, 32'h1234_5727};
	exp_tab[14] = {5'd14, 32'h0000_0007};
	exp_tab[15] = {5'd15, 32'h0000_0001};
	exp_tab[16] = {5'd16, 32'h0000_0002};
	exp_tab[17] = {5'd17, 32'h1234_5678};
	exp_tab[18] = {5'd18, 32'h1234_567d};
	exp_tab[19] = {5'd20, 32'h0000_0020};
	exp_tab[20] = {5'd21, 32'h0000_0020};
	exp_tab[21] = {5'd22, 32'h0000_0055};
	exp_tab[22] = {5'd23, 32'h0000_0040};
	// jal at 0x7c links 0x84
	exp_tab[23] = {5'd31, 32'h0000_0084};
	exp_tab[24] = {5'd25, 32'h0000_0084};
	exp_tab[25] = {5'd26, 32'h0000_0089};
	exp_tab[26] = {5'd27, 32'h0000_0005};
	exp_tab[27] = {5'd28, 32'h0000_0005};
endtask

// File: bench/tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 10;
	// Idle time that must stay free of writes
	localparam int quiet_cycles = 20;

	logic        clk;
	logic        rst;
	logic [31:0] imem_data;
	logic [31:0] imem_addr;
	logic        wb_en;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;

	`include "tb_program.svh"

	localparam int watchdog_cycles = 20 * exp_writes + 100;

	mips_top u_dut (
		.clk(clk),
		.rst(rst),
		.imem_data(imem_data),
		.imem_addr(imem_addr),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	//////////////////////////////////////////////////
	// Clock and instruction server
	//////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Nop past the end of the program
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		if ($isunknown(addr))
			return 32'h0000_0000;
		idx = int'(addr >> 2);
		if (idx >= prog_words)
			return 32'h0000_0000;
		return prog[idx];
	endfunction

	// Same-cycle answer to the F-stage PC
	assign imem_data = fetch_word(imem_addr);

	//////////////////////////////////////////////////
	// Failure and trace checks
	//////////////////////////////////////////////////
	task automatic stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	// Mid-cycle sample, W commits on the next rising edge
	task automatic wait_for_write();
		do begin
			@(negedge clk);
			assert (!$isunknown(wb_en)) else begin
				$display("write enable of the trace port is unknown after reset");
				stop_with_failure();
			end
		end while (wb_en !== 1'b1);
	endtask

	task automatic check_write(input int n);
		logic [4:0]  want_reg;
		logic [31:0] want_val;
		want_reg = exp_tab[n][36:32];
		want_val = exp_tab[n][31:0];
		assert (wb_reg === want_reg) else begin
			$display("error: wb_reg at write %0d is 0x%h, expected 0x%h", n, wb_reg, want_reg);
			stop_with_failure();
		end
		assert (wb_data === want_val) else begin
			$display("error: wb_data at write %0d is 0x%h, expected 0x%h", n, wb_data, want_val);
			stop_with_failure();
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		rst = 1'b1;
		load_tables();
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		// Walk the expected trace in program order
		for (int n = 0; n < exp_writes; n++) begin
			wait_for_write();
			check_write(n);
		end
		// Nothing may write after the last entry
		for (int q = 0; q < quiet_cycles; q++) begin
			@(negedge clk);
			assert (wb_en !== 1'b1) else begin
				$display("extra register write after the expected trace: reg 0x%h data 0x%h",
					wb_reg, wb_data);
				stop_with_failure();
			end
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Watchdog, scaled to the length of the trace
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the expected register writes did not all appear in time");
		stop_with_failure();
	end

endmodule

// File: compile.f
+incdir+bench
verilog/mips_pkg.sv
verilog/bypass.sv
verilog/stall_ctrl.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/mips_core.sv
verilog/mips_top.sv
bench/tb_mips.sv

// File: Bender.yml
package:
  name: mips_bypass

sources:
  - verilog/mips_pkg.sv
  - verilog/bypass.sv
  - verilog/stall_ctrl.sv
  - verilog/decoder.sv
  - verilog/reg_file.sv
  - verilog/alu.sv
  - verilog/data_mem.sv
  - verilog/mips_core.sv
  - verilog/mips_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_mips.sv
